//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass or fail is decided by the pass message in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- rtl/commit_monitor_top.sv
// Commit-side observation unit of an in-order core.
// Combines the exception-storm guard, the per-port trace encoder,
// one retired-PC queue per commit port and the round-robin PC merge.
// All inputs are sampled on clk_i, all outputs are registered.

`default_nettype none

module commit_monitor_top (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  trace_pkg::commit_port_t [trace_pkg::NrCommitPorts-1:0]  commit_i,
  input  logic [dos_pkg::NrExcSources-1:0]                        exc_valid_i,
  input  trace_pkg::priv_lvl_e                                    priv_lvl_i,
  input  logic                                                    debug_mode_i,
  output trace_pkg::trace_t [trace_pkg::NrCommitPorts-1:0]        trace_o,
  output logic                                                    halt_dos_o,
  output logic                                                    pc_valid_o,
  output logic [trace_pkg::VLen-1:0]                              pc_o
);

  // Queue to arbiter
  logic [trace_pkg::NrCommitPorts-1:0]                      pc_empty;
  logic [trace_pkg::NrCommitPorts-1:0][trace_pkg::VLen-1:0] pc_head;
  logic [trace_pkg::NrCommitPorts-1:0]                      pc_pop;

  // ------------------------------------------------------------
  // Exception-storm guard
  // ------------------------------------------------------------
  dos_guard i_dos_guard (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .exc_valid_i ( exc_valid_i ),
    .halt_dos_o  ( halt_dos_o  )
  );

  // ------------------------------------------------------------
  // Trace port
  // ------------------------------------------------------------
  trace_encoder i_trace_encoder (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .commit_i     ( commit_i     ),
    .priv_lvl_i   ( priv_lvl_i   ),
    .debug_mode_i ( debug_mode_i ),
    .trace_o      ( trace_o      )
  );

  // ------------------------------------------------------------
  // Retired PC queues and merge
  // ------------------------------------------------------------
  for (genvar i = 0; i < trace_pkg::NrCommitPorts; i++) begin : gen_pc_queue
    pc_queue #(
      .Depth ( trace_pkg::PcQueueDepth )
    ) i_pc_queue (
      .clk_i    ( clk_i       ),
      .rst_ni   ( rst_ni      ),
      .commit_i ( commit_i[i] ),
      .pop_i    ( pc_pop[i]   ),
      .empty_o  ( pc_empty[i] ),
      .pc_o     ( pc_head[i]  )
    );
  end

  pc_arbiter i_pc_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( pc_empty   ),
    .head_pc_i  ( pc_head    ),
    .pop_o      ( pc_pop     ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       )
  );

endmodule

`default_nettype wire

//--- rtl/dos_guard.sv
// Exception-storm guard.
// Counts cycles with at least one valid exception source and raises
// halt_dos_o once the count reaches the threshold. The halt holds
// until reset.

`default_nettype none

module dos_guard (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [dos_pkg::NrExcSources-1:0] exc_valid_i,
  output logic                             halt_dos_o
);

  localparam logic [dos_pkg::ExcCountWidth-1:0] CountMax =
    dos_pkg::ExcCountWidth'(dos_pkg::ExcThreshold);

  logic                              exc_event;
  logic [dos_pkg::ExcCountWidth-1:0] count_d, count_q;
  dos_pkg::guard_state_e             state_d, state_q;

  // Several sources in one cycle still count once
  assign exc_event = |exc_valid_i;

  // Saturating event counter
  always_comb begin
    count_d = count_q;
    if (exc_event && (count_q < CountMax)) begin
      count_d = count_q + 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Guard FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      dos_pkg::GUARD_COUNT: begin
        // Halt in the cycle after the threshold event
        if (count_d == CountMax) begin
          state_d = dos_pkg::GUARD_HALT;
        end
      end
      dos_pkg::GUARD_HALT: state_d = dos_pkg::GUARD_HALT;
      default: state_d = dos_pkg::GUARD_COUNT;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      state_q <= dos_pkg::GUARD_COUNT;
    end else begin
      count_q <= count_d;
      state_q <= state_d;
    end
  end

  assign halt_dos_o = (state_q == dos_pkg::GUARD_HALT);

endmodule

`default_nettype wire

//--- rtl/dos_pkg.sv
// Constants and state type of the exception-storm guard.
// Referenced by scoped names only.

`default_nettype none

package dos_pkg;

  // Commit, fixed-latency unit, load, store, FPU and CSR
  localparam int unsigned NrExcSources  = 6;
  // Exception cycles tolerated before the core is halted
  localparam int unsigned ExcThreshold  = 4;
  localparam int unsigned ExcCountWidth = $clog2(ExcThreshold) + 1;

  typedef enum logic [0:0] {
    GUARD_COUNT = 1'b0,
    GUARD_HALT  = 1'b1
  } guard_state_e;

endpackage

`default_nettype wire

//--- rtl/pc_arbiter.sv
// Round-robin merge of the retired-PC queues.
// Grants the first non-empty queue at or after the pointer, pops it
// and moves the pointer past the winner. The granted PC leaves on
// pc_o one cycle later, qualified by pc_valid_o.

`default_nettype none

module pc_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic [trace_pkg::NrCommitPorts-1:0]                  empty_i,
  input  logic [trace_pkg::NrCommitPorts-1:0][trace_pkg::VLen-1:0] head_pc_i,
  output logic [trace_pkg::NrCommitPorts-1:0]                  pop_o,
  output logic                                                 pc_valid_o,
  output logic [trace_pkg::VLen-1:0]                           pc_o
);

  localparam int unsigned IdxWidth = $clog2(trace_pkg::NrCommitPorts);

  logic [IdxWidth-1:0]        ptr_q, ptr_d;
  logic [IdxWidth-1:0]        cand, gnt_idx;
  logic                       gnt_found;
  logic                       pc_valid_q;
  logic [trace_pkg::VLen-1:0] pc_q;

  // First non-empty queue at or after the pointer
  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = '0;
    cand      = '0;
    pop_o     = '0;
    for (int unsigned i = 0; i < trace_pkg::NrCommitPorts; i++) begin
      cand = IdxWidth'((32'(ptr_q) + i) % trace_pkg::NrCommitPorts);
      if (!gnt_found && !empty_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
    pop_o[gnt_idx] = gnt_found;
  end

  // Pointer moves one past the winner
  always_comb begin
    ptr_d = ptr_q;
    if (gnt_found) begin
      if (gnt_idx == IdxWidth'(trace_pkg::NrCommitPorts - 1)) begin
        ptr_d = '0;
      end else begin
        ptr_d = gnt_idx + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Output stream
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q      <= '0;
      pc_valid_q <= 1'b0;
    end else begin
      ptr_q      <= ptr_d;
      pc_valid_q <= gnt_found;
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_found) begin
      pc_q <= head_pc_i[gnt_idx];
    end
  end

  assign pc_valid_o = pc_valid_q;
  assign pc_o       = pc_q;

endmodule

`default_nettype wire

//--- rtl/pc_queue.sv
// Retired-PC FIFO of one commit port.
// Pushes the PC of every slot that retires without an exception and
// drops the push when full. The head is shown combinationally and is
// valid while empty_o is low. Depth must be a power of two.

`default_nettype none

module pc_queue #(
  parameter int unsigned Depth = trace_pkg::PcQueueDepth
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  trace_pkg::commit_port_t      commit_i,
  input  logic                         pop_i,
  output logic                         empty_o,
  output logic [trace_pkg::VLen-1:0]   pc_o
);

  localparam int unsigned PtrWidth = $clog2(Depth);

  logic [trace_pkg::VLen-1:0] mem_q [Depth];
  logic [PtrWidth-1:0]        wr_ptr_q, rd_ptr_q;
  logic [PtrWidth:0]          count_q;
  logic                       full;
  logic                       push, pop;

  assign full    = (count_q == (PtrWidth+1)'(Depth));
  assign empty_o = (count_q == '0);

  // Excepting slots carry no retired PC
  assign push = commit_i.ack & ~commit_i.ex_valid & ~full;
  assign pop  = pop_i & ~empty_o;

  // ------------------------------------------------------------
  // Pointers and fill count
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= commit_i.pc;
    end
  end

  assign pc_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- rtl/trace_encoder.sv
// Trace port encoder.
// Turns each commit slot into a trace record: retired instruction,
// exception or interrupt, with PC, instruction word, cause and mode.
// Records appear one cycle after the commit.

`default_nettype none

module trace_encoder (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  trace_pkg::commit_port_t [trace_pkg::NrCommitPorts-1:0] commit_i,
  input  trace_pkg::priv_lvl_e                                   priv_lvl_i,
  input  logic                                                   debug_mode_i,
  output trace_pkg::trace_t [trace_pkg::NrCommitPorts-1:0]       trace_o
);

  trace_pkg::priv_mode_e                                mode;
  trace_pkg::trace_t [trace_pkg::NrCommitPorts-1:0]     trace_d, trace_q;

  // Debug mode overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode = trace_pkg::MODE_D;
    end else begin
      case (priv_lvl_i)
        trace_pkg::PRIV_LVL_U: mode = trace_pkg::MODE_U;
        trace_pkg::PRIV_LVL_S: mode = trace_pkg::MODE_S;
        default:               mode = trace_pkg::MODE_M;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Per-slot classification
  // ------------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < trace_pkg::NrCommitPorts; i++) begin
      trace_d[i].valid     = commit_i[i].ack & ~commit_i[i].ex_valid;
      trace_d[i].exception = commit_i[i].ack & commit_i[i].ex_valid &
                             ~commit_i[i].cause[trace_pkg::CauseIrqBit];
      trace_d[i].interrupt = commit_i[i].ack & commit_i[i].ex_valid &
                             commit_i[i].cause[trace_pkg::CauseIrqBit];
      trace_d[i].iaddr     = commit_i[i].pc;
      // tval holds the instruction word for retired slots
      trace_d[i].insn      = commit_i[i].tval[trace_pkg::InsnWidth-1:0];
      trace_d[i].cause     = commit_i[i].cause;
      trace_d[i].tval      = commit_i[i].tval[trace_pkg::InsnWidth-1:0];
      trace_d[i].mode      = mode;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trace_q <= '0;
    end else begin
      trace_q <= trace_d;
    end
  end

  assign trace_o = trace_q;

endmodule

`default_nettype wire

//--- rtl/trace_pkg.sv
// Commit slot and trace record types shared by the commit monitor.
// Widths follow a 64-bit core with two commit ports.
// Referenced by scoped names from the RTL and the testbench.

`default_nettype none

package trace_pkg;

  // ------------------------------------------------------------
  // Widths and sizes
  // ------------------------------------------------------------
  localparam int unsigned NrCommitPorts = 2;
  localparam int unsigned XLen          = 64;
  localparam int unsigned VLen          = 64;
  localparam int unsigned InsnWidth     = 32;
  localparam int unsigned PcQueueDepth  = 16;
  // Set in the cause of an interrupt
  localparam int unsigned CauseIrqBit   = 63;

  // Mode as reported on the trace port
  typedef enum logic [1:0] {
    MODE_U = 2'b00,
    MODE_S = 2'b01,
    MODE_D = 2'b10,
    MODE_M = 2'b11
  } priv_mode_e;

  // Privilege level as delivered by the core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // ------------------------------------------------------------
  // Records
  // ------------------------------------------------------------
  typedef struct packed {
    logic            ack;
    logic            ex_valid;
    logic [XLen-1:0] cause;
    logic [XLen-1:0] tval;
    logic [VLen-1:0] pc;
  } commit_port_t;

  typedef struct packed {
    logic                 valid;
    logic                 exception;
    logic                 interrupt;
    logic [VLen-1:0]      iaddr;
    logic [InsnWidth-1:0] insn;
    logic [XLen-1:0]      cause;
    logic [InsnWidth-1:0] tval;
    priv_mode_e           mode;
  } trace_t;

endpackage

`default_nettype wire

//--- tb.f
rtl/trace_pkg.sv
rtl/dos_pkg.sv
rtl/dos_guard.sv
rtl/trace_encoder.sv
rtl/pc_queue.sv
rtl/pc_arbiter.sv
rtl/commit_monitor_top.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- tb/tb_checker.sv
// Checker for the commit monitor testbench.
// Watches the DUT ports, keeps reference models of the trace port, the
// exception guard and the retired-PC stream, and compares on every
// falling edge. Also ends the run through timed_out_o at a cycle limit.

`default_nettype none

module tb_checker #(
  parameter int MaxCycles = 1000
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  trace_pkg::commit_port_t [trace_pkg::NrCommitPorts-1:0] commit_i,
  input  logic [dos_pkg::NrExcSources-1:0]                       exc_valid_i,
  input  trace_pkg::priv_lvl_e                                   priv_lvl_i,
  input  logic                                                   debug_mode_i,
  input  trace_pkg::trace_t [trace_pkg::NrCommitPorts-1:0]       trace_i,
  input  logic                                                   halt_dos_i,
  input  logic                                                   pc_valid_i,
  input  logic [trace_pkg::VLen-1:0]                             pc_i,
  input  logic                                                   fair_check_i,
  output int                                                     errors_o,
  output int                                                     pending_o,
  output logic                                                   timed_out_o
);
  timeunit 1ns;
  timeprecision 1ps;

  trace_pkg::trace_t [trace_pkg::NrCommitPorts-1:0] exp_trace;
  logic [trace_pkg::VLen-1:0] exp_pc [trace_pkg::NrCommitPorts][$];
  int   exp_count  = 0;
  logic exp_halt   = 1'b0;
  int   errors     = 0;
  int   pending    = 0;
  int   cycles     = 0;
  int   last_port  = 0;
  logic last_valid = 1'b0;
  logic timed_out  = 1'b0;

  // ------------------------------------------------------------
  // Reference models
  // ------------------------------------------------------------
  function automatic trace_pkg::trace_t ref_trace(input trace_pkg::commit_port_t c,
                                                  input trace_pkg::priv_lvl_e lvl,
                                                  input logic dbg);
    trace_pkg::trace_t t;
    t.valid     = c.ack & ~c.ex_valid;
    t.exception = c.ack & c.ex_valid & ~c.cause[trace_pkg::CauseIrqBit];
    t.interrupt = c.ack & c.ex_valid & c.cause[trace_pkg::CauseIrqBit];
    t.iaddr     = c.pc;
    t.insn      = c.tval[trace_pkg::InsnWidth-1:0];
    t.cause     = c.cause;
    t.tval      = c.tval[trace_pkg::InsnWidth-1:0];
    if (dbg) t.mode = trace_pkg::MODE_D;
    else if (lvl == trace_pkg::PRIV_LVL_U) t.mode = trace_pkg::MODE_U;
    else if (lvl == trace_pkg::PRIV_LVL_S) t.mode = trace_pkg::MODE_S;
    else t.mode = trace_pkg::MODE_M;
    return t;
  endfunction

  // One count per cycle with any strobe, held at the threshold
  function automatic int ref_guard_count(input int count,
                                         input logic [dos_pkg::NrExcSources-1:0] strobes);
    if (strobes != '0 && count < int'(dos_pkg::ExcThreshold)) return count + 1;
    else return count;
  endfunction

  task automatic check_reset_state();
    for (int p = 0; p < trace_pkg::NrCommitPorts; p++) begin
      if ({trace_i[p].valid, trace_i[p].exception, trace_i[p].interrupt} !== 3'b000) begin
        $display("FAILED trace_o[%0d] flags got %h expected 0", p,
                 {trace_i[p].valid, trace_i[p].exception, trace_i[p].interrupt});
        errors++;
      end
    end
    if ({halt_dos_i, pc_valid_i} !== 2'b00) begin
      $display("FAILED halt_dos_o,pc_valid_o got %h expected 0", {halt_dos_i, pc_valid_i});
      errors++;
    end
  endtask

  // Port number sits in the top byte of every PC
  task automatic check_pc();
    int port;
    logic [trace_pkg::VLen-1:0] expected;
    port = int'(pc_i[trace_pkg::VLen-1 -: 8]);
    if (port >= trace_pkg::NrCommitPorts || exp_pc[port].size() == 0) begin
      $display("PC %h came out of the stream without a matching retired commit", pc_i);
      errors++;
    end else begin
      expected = exp_pc[port].pop_front();
      if (pc_i !== expected) begin
        $display("FAILED pc_o got %h expected %h", pc_i, expected);
        errors++;
      end
      if (fair_check_i && last_valid && port == last_port) begin
        $display("Round-robin granted port %0d twice in a row", port);
        errors++;
      end
      last_port  = port;
      last_valid = 1'b1;
    end
  endtask

  // ------------------------------------------------------------
  // Compare, then advance with the inputs of the next rising edge
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      check_reset_state();
      exp_trace  = '0;
      exp_count  = 0;
      exp_halt   = 1'b0;
      last_valid = 1'b0;
      for (int p = 0; p < trace_pkg::NrCommitPorts; p++) exp_pc[p].delete();
    end else begin
      for (int p = 0; p < trace_pkg::NrCommitPorts; p++) begin
        if (trace_i[p] !== exp_trace[p]) begin
          $display("FAILED trace_o[%0d] got %h expected %h", p, trace_i[p], exp_trace[p]);
          errors++;
        end
      end
      if (halt_dos_i !== exp_halt) begin
        $display("FAILED halt_dos_o got %h expected %h", halt_dos_i, exp_halt);
        errors++;
      end
      if (pc_valid_i) check_pc();
      if (!fair_check_i) last_valid = 1'b0;
      for (int p = 0; p < trace_pkg::NrCommitPorts; p++) begin
        exp_trace[p] = ref_trace(commit_i[p], priv_lvl_i, debug_mode_i);
        if (commit_i[p].ack && !commit_i[p].ex_valid) exp_pc[p].push_back(commit_i[p].pc);
      end
      exp_count = ref_guard_count(exp_count, exc_valid_i);
      exp_halt  = exp_halt | (exp_count >= int'(dos_pkg::ExcThreshold));
    end
    pending = 0;
    for (int p = 0; p < trace_pkg::NrCommitPorts; p++) pending += exp_pc[p].size();
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) timed_out <= 1'b1;
  end

  assign errors_o    = errors;
  assign pending_o   = pending;
  assign timed_out_o = timed_out;

endmodule

`default_nettype wire

//--- tb/tb_top.sv
// Testbench top for the commit monitor.
// Drives random commits, mode changes and exception strobes into the
// DUT, leaves the comparing to tb_checker and prints the test results.

`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TraceCommits = 64;
  localparam int StreamBursts = 12;
  localparam int MaxBurst     = 8;
  localparam int FairCycles   = 8;
  localparam int GuardCycles  = 24;
  // Four times the summed test lengths, plus the resets
  localparam int MaxCycles = 4 * (2 * TraceCommits + StreamBursts * 3 * MaxBurst
                                  + 3 * FairCycles + GuardCycles) + 64;

  logic                                                   clk;
  logic                                                   rst_n;
  trace_pkg::commit_port_t [trace_pkg::NrCommitPorts-1:0] commit;
  logic [dos_pkg::NrExcSources-1:0]                       exc_valid;
  trace_pkg::priv_lvl_e                                   priv_lvl;
  logic                                                   debug_mode;
  trace_pkg::trace_t [trace_pkg::NrCommitPorts-1:0]       trace;
  logic                                                   halt_dos, pc_valid, fair_check;
  logic [trace_pkg::VLen-1:0]                             pc;
  logic                                                   timed_out;
  int                                                     errors, pending;
  int                                                     err_base, tests_run, tests_failed;
  logic [31:0]                                            lfsr_q;

  commit_monitor_top uut (
    .clk_i (clk), .rst_ni (rst_n), .commit_i (commit), .exc_valid_i (exc_valid),
    .priv_lvl_i (priv_lvl), .debug_mode_i (debug_mode), .trace_o (trace),
    .halt_dos_o (halt_dos), .pc_valid_o (pc_valid), .pc_o (pc)
  );

  tb_checker #(.MaxCycles (MaxCycles)) i_checker (
    .clk_i (clk), .rst_ni (rst_n), .commit_i (commit), .exc_valid_i (exc_valid),
    .priv_lvl_i (priv_lvl), .debug_mode_i (debug_mode), .trace_i (trace),
    .halt_dos_i (halt_dos), .pc_valid_i (pc_valid), .pc_i (pc),
    .fair_check_i (fair_check), .errors_o (errors), .pending_o (pending),
    .timed_out_o (timed_out)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) next = next ^ 32'h8020_0003;
    return next;
  endfunction

  task automatic draw_bits(input int n, output logic [63:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_q[0];
      lfsr_q  = lfsr_next(lfsr_q);
    end
  endtask

  task automatic random_commit(input int port, input logic force_ack,
                               output trace_pkg::commit_port_t slot);
    logic [63:0] r;
    slot = '0;
    draw_bits(4, r);
    slot.ack      = r[0] | force_ack;
    slot.ex_valid = (r[2:1] == 2'b00);
    slot.cause[trace_pkg::CauseIrqBit] = r[3];
    draw_bits(32, r);
    slot.cause[3:0] = r[3:0];
    slot.tval       = {32'h0, r[31:0]};
    draw_bits(32, r);
    slot.pc = {8'(port), 24'h0, r[31:0]};
  endtask

  task automatic drive_idle();
    @(posedge clk);
    commit    <= '0;
    exc_valid <= '0;
  endtask

  task automatic exc_cycle(input logic [dos_pkg::NrExcSources-1:0] strobes);
    @(posedge clk);
    commit    <= '0;
    exc_valid <= strobes;
  endtask

  task automatic apply_reset();
    drive_idle();
    rst_n <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // The stream has drained once the checker expects no more PCs
  task automatic wait_drain();
    drive_idle();
    while (pending != 0) @(posedge clk);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_base) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, errors - err_base);
    end
    err_base = errors;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    trace_pkg::commit_port_t slot;
    logic [63:0] r;
    int len;
    rst_n = 1'b0;
    commit = '0;
    exc_valid = '0;
    priv_lvl = trace_pkg::PRIV_LVL_M;
    debug_mode = 1'b0;
    fair_check = 1'b0;
    lfsr_q = 32'd10;
    err_base = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) drive_idle();
    finish_test("reset");

    // Commits on every other cycle keep the PC queues shallow
    for (int n = 0; n < TraceCommits; n++) begin
      @(posedge clk);
      for (int p = 0; p < trace_pkg::NrCommitPorts; p++) begin
        random_commit(p, 1'b0, slot);
        commit[p] <= slot;
      end
      draw_bits(3, r);
      priv_lvl <= (r[1:0] == 2'b10) ? trace_pkg::PRIV_LVL_M : trace_pkg::priv_lvl_e'(r[1:0]);
      debug_mode <= r[2];
      drive_idle();
    end
    wait_drain();
    finish_test("trace");

    for (int b = 0; b < StreamBursts; b++) begin
      draw_bits(3, r);
      len = int'(r[2:0]) + 1;
      for (int n = 0; n < len; n++) begin
        @(posedge clk);
        for (int p = 0; p < trace_pkg::NrCommitPorts; p++) begin
          random_commit(p, 1'b0, slot);
          commit[p] <= slot;
        end
      end
      wait_drain();
    end
    finish_test("stream");

    fair_check <= 1'b1;
    for (int n = 0; n < FairCycles; n++) begin
      @(posedge clk);
      for (int p = 0; p < trace_pkg::NrCommitPorts; p++) begin
        random_commit(p, 1'b1, slot);
        slot.ex_valid = 1'b0;
        commit[p] <= slot;
      end
    end
    wait_drain();
    fair_check <= 1'b0;
    finish_test("fairness");

    // Threshold minus one exception cycles, one with several sources
    apply_reset();
    for (int n = 0; n < int'(dos_pkg::ExcThreshold) - 1; n++) begin
      exc_cycle((n == 1) ? 6'b101101 : 6'b000001 << n);
      drive_idle();
    end
    repeat (3) drive_idle();
    exc_cycle(6'b100010);
    repeat (3) drive_idle();
    exc_cycle(6'b111111);
    repeat (2) drive_idle();
    apply_reset();
    repeat (2) drive_idle();
    finish_test("guard");

    $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    wait (timed_out);
    $display("Cycle limit of %0d reached before the tests completed", MaxCycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
